/* hw/soc_pkg.sv */
package soc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] bus_addr_t;  // Byte address.
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_be_t;
  typedef logic [7:0]  gpi_t;
  typedef logic [15:0] gpo_t;
  typedef logic [63:0] mtime_t;

  typedef enum logic [1:0] {
    Ram,
    Gpio,
    Timer,
    NoDev  // Unmapped address.
  } bus_device_e;

  ////////////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////////////

  localparam bus_addr_t   RamStart     = 32'h0010_0000;
  localparam int unsigned RamSizeBytes = 16 * 1024;
  localparam bus_addr_t   RamMask      = ~bus_addr_t'(RamSizeBytes - 1);
  localparam int unsigned RamWords     = RamSizeBytes / 4;
  localparam int unsigned RamIdxWidth  = $clog2(RamWords);

  localparam bus_addr_t GpioStart = 32'h8000_0000;
  localparam bus_addr_t GpioMask  = ~bus_addr_t'(4 * 1024 - 1);

  localparam bus_addr_t TimerStart = 32'h8000_2000;
  localparam bus_addr_t TimerMask  = ~bus_addr_t'(4 * 1024 - 1);

  // Register offsets within a 4 KiB device window.
  localparam int unsigned DevOffsWidth = 12;

  localparam logic [DevOffsWidth-1:0] GpioOutOffs = 12'h000;
  localparam logic [DevOffsWidth-1:0] GpioInOffs  = 12'h004;

  localparam logic [DevOffsWidth-1:0] MtimeLoOffs    = 12'h000;
  localparam logic [DevOffsWidth-1:0] MtimeHiOffs    = 12'h004;
  localparam logic [DevOffsWidth-1:0] MtimecmpLoOffs = 12'h008;
  localparam logic [DevOffsWidth-1:0] MtimecmpHiOffs = 12'h00C;

endpackage

/* hw/bus_decoder.sv */
module bus_decoder import soc_pkg::*; (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,

  input  logic      bus_req_i,
  input  bus_addr_t bus_addr_i,

  output logic      ram_req_o,
  output logic      gpio_req_o,
  output logic      timer_req_o,

  input  logic      ram_rvalid_i,
  input  bus_data_t ram_rdata_i,
  input  logic      gpio_rvalid_i,
  input  bus_data_t gpio_rdata_i,
  input  logic      timer_rvalid_i,
  input  bus_data_t timer_rdata_i,
  input  logic      timer_err_i,

  output logic      bus_rvalid_o,
  output bus_data_t bus_rdata_o,
  output logic      bus_err_o
);

  bus_device_e dev_sel;
  bus_device_e dev_sel_q;
  logic        pending_q;  // A response is due this cycle.

  always_comb begin
    if ((bus_addr_i & RamMask) == RamStart) begin
      dev_sel = Ram;
    end else if ((bus_addr_i & GpioMask) == GpioStart) begin
      dev_sel = Gpio;
    end else if ((bus_addr_i & TimerMask) == TimerStart) begin
      dev_sel = Timer;
    end else begin
      dev_sel = NoDev;
    end
  end

  assign ram_req_o   = bus_req_i & (dev_sel == Ram);
  assign gpio_req_o  = bus_req_i & (dev_sel == Gpio);
  assign timer_req_o = bus_req_i & (dev_sel == Timer);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      pending_q <= 1'b0;
      dev_sel_q <= NoDev;
    end else begin
      pending_q <= bus_req_i;
      if (bus_req_i) begin
        dev_sel_q <= dev_sel;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    bus_rvalid_o = 1'b0;
    bus_rdata_o  = '0;
    bus_err_o    = 1'b0;
    case (dev_sel_q)
      Ram: begin
        bus_rvalid_o = ram_rvalid_i;
        bus_rdata_o  = ram_rdata_i;
      end
      Gpio: begin
        bus_rvalid_o = gpio_rvalid_i;
        bus_rdata_o  = gpio_rdata_i;
      end
      Timer: begin
        bus_rvalid_o = timer_rvalid_i;
        bus_rdata_o  = timer_rdata_i;
        bus_err_o    = timer_err_i;
      end
      default: begin
        bus_rvalid_o = pending_q;  // Error response, data stays zero.
        bus_err_o    = pending_q;
      end
    endcase
  end

  property p_rvalid_from_sel(logic rvalid, bus_device_e dev);
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
      rvalid |-> pending_q && (dev_sel_q == dev);
  endproperty

  a_ram_rvalid:   assert property (p_rvalid_from_sel(ram_rvalid_i, Ram));
  a_gpio_rvalid:  assert property (p_rvalid_from_sel(gpio_rvalid_i, Gpio));
  a_timer_rvalid: assert property (p_rvalid_from_sel(timer_rvalid_i, Timer));

endmodule

/* hw/soc_ram.sv */
module soc_ram import soc_pkg::*; (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,

  input  logic      req_i,
  input  logic      we_i,
  input  bus_addr_t addr_i,
  input  bus_be_t   be_i,
  input  bus_data_t wdata_i,

  output logic      rvalid_o,
  output bus_data_t rdata_o
);

  bus_data_t              mem [RamWords];
  logic [RamIdxWidth-1:0] word_idx;

  assign word_idx = addr_i[RamIdxWidth+1:2];

  // Byte-enabled write, registered read.
  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int unsigned i = 0; i < 4; i++) begin
          if (be_i[i]) begin
            mem[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      rdata_o <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

  a_addr_known: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    req_i |-> !$isunknown(addr_i));

endmodule

/* hw/gpio_regs.sv */
module gpio_regs import soc_pkg::*; (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,

  input  logic      req_i,
  input  logic      we_i,
  input  bus_addr_t addr_i,
  input  bus_be_t   be_i,
  input  bus_data_t wdata_i,

  output logic      rvalid_o,
  output bus_data_t rdata_o,

  input  gpi_t      gp_i,
  output gpo_t      gp_o
);

  logic [DevOffsWidth-1:0] reg_offs;
  logic                    out_we;
  gpi_t                    gp_sync1_q;
  gpi_t                    gp_sync2_q;

  assign reg_offs = {addr_i[DevOffsWidth-1:2], 2'b00};  // Word aligned.
  assign out_we   = req_i & we_i & (reg_offs == GpioOutOffs);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o       <= '0;
      gp_sync1_q <= '0;
      gp_sync2_q <= '0;
      rvalid_o   <= 1'b0;
    end else begin
      if (out_we && be_i[0]) gp_o[7:0]  <= wdata_i[7:0];
      if (out_we && be_i[1]) gp_o[15:8] <= wdata_i[15:8];
      gp_sync1_q <= gp_i;  // Two-flop input sync.
      gp_sync2_q <= gp_sync1_q;
      rvalid_o   <= req_i;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (reg_offs)
        GpioOutOffs: rdata_o <= bus_data_t'(gp_o);
        GpioInOffs:  rdata_o <= bus_data_t'(gp_sync2_q);
        default:     rdata_o <= '0;
      endcase
    end
  end

endmodule

/* hw/machine_timer.sv */
module machine_timer import soc_pkg::*; (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,

  input  logic      req_i,
  input  logic      we_i,
  input  bus_addr_t addr_i,
  input  bus_be_t   be_i,
  input  bus_data_t wdata_i,

  output logic      rvalid_o,
  output bus_data_t rdata_o,
  output logic      err_o,

  output logic      timer_irq_o
);

  logic [DevOffsWidth-1:0] reg_offs;
  logic                    bad_offs;
  logic                    cmp_lo_we;
  logic                    cmp_hi_we;
  mtime_t                  mtime_q;
  mtime_t                  mtimecmp_q;

  assign reg_offs  = {addr_i[DevOffsWidth-1:2], 2'b00};
  assign bad_offs  = reg_offs > MtimecmpHiOffs;  // 0x10 and up.
  assign cmp_lo_we = req_i & we_i & (reg_offs == MtimecmpLoOffs);
  assign cmp_hi_we = req_i & we_i & (reg_offs == MtimecmpHiOffs);

  ////////////////////////////////////////////////////////////////////////////
  // Counter, compare and interrupt
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // Each half takes its own byte enables.
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtimecmp_q <= '1;
    end else begin
      for (int unsigned i = 0; i < 4; i++) begin
        if (cmp_lo_we && be_i[i]) begin
          mtimecmp_q[8*i +: 8] <= wdata_i[8*i +: 8];
        end
        if (cmp_hi_we && be_i[i]) begin
          mtimecmp_q[32+8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      timer_irq_o <= 1'b0;
    end else begin
      timer_irq_o <= mtime_q >= mtimecmp_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
    end else begin
      rvalid_o <= req_i;
      err_o    <= req_i & bad_offs;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (reg_offs)
        MtimeLoOffs:    rdata_o <= mtime_q[31:0];
        MtimeHiOffs:    rdata_o <= mtime_q[63:32];
        MtimecmpLoOffs: rdata_o <= mtimecmp_q[31:0];
        MtimecmpHiOffs: rdata_o <= mtimecmp_q[63:32];
        default:        rdata_o <= '0;
      endcase
    end
  end

endmodule

/* hw/demo_soc_top.sv */
module demo_soc_top import soc_pkg::*; (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,

  input  logic      bus_req_i,
  input  logic      bus_we_i,
  input  bus_addr_t bus_addr_i,
  input  bus_be_t   bus_be_i,
  input  bus_data_t bus_wdata_i,
  output logic      bus_rvalid_o,
  output bus_data_t bus_rdata_o,
  output logic      bus_err_o,

  input  gpi_t      gp_i,
  output gpo_t      gp_o,
  output logic      timer_irq_o
);

  logic      ram_req;
  logic      ram_rvalid;
  bus_data_t ram_rdata;

  logic      gpio_req;
  logic      gpio_rvalid;
  bus_data_t gpio_rdata;

  logic      timer_req;
  logic      timer_rvalid;
  bus_data_t timer_rdata;
  logic      timer_err;

  bus_decoder u_bus_decoder (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .bus_req_i     (bus_req_i),
    .bus_addr_i    (bus_addr_i),
    .ram_req_o     (ram_req),
    .gpio_req_o    (gpio_req),
    .timer_req_o   (timer_req),
    .ram_rvalid_i  (ram_rvalid),
    .ram_rdata_i   (ram_rdata),
    .gpio_rvalid_i (gpio_rvalid),
    .gpio_rdata_i  (gpio_rdata),
    .timer_rvalid_i(timer_rvalid),
    .timer_rdata_i (timer_rdata),
    .timer_err_i   (timer_err),
    .bus_rvalid_o  (bus_rvalid_o),
    .bus_rdata_o   (bus_rdata_o),
    .bus_err_o     (bus_err_o)
  );

  // Devices share we, addr, be and wdata from the host.
  soc_ram u_ram (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (ram_req),
    .we_i      (bus_we_i),
    .addr_i    (bus_addr_i),
    .be_i      (bus_be_i),
    .wdata_i   (bus_wdata_i),
    .rvalid_o  (ram_rvalid),
    .rdata_o   (ram_rdata)
  );

  gpio_regs u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (gpio_req),
    .we_i      (bus_we_i),
    .addr_i    (bus_addr_i),
    .be_i      (bus_be_i),
    .wdata_i   (bus_wdata_i),
    .rvalid_o  (gpio_rvalid),
    .rdata_o   (gpio_rdata),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  machine_timer u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (timer_req),
    .we_i       (bus_we_i),
    .addr_i     (bus_addr_i),
    .be_i       (bus_be_i),
    .wdata_i    (bus_wdata_i),
    .rvalid_o   (timer_rvalid),
    .rdata_o    (timer_rdata),
    .err_o      (timer_err),
    .timer_irq_o(timer_irq_o)
  );

endmodule

/* include/tb_demo_soc_model.svh */
`ifndef TB_DEMO_SOC_MODEL_SVH
`define TB_DEMO_SOC_MODEL_SVH

// Shadow RAM by word index, plus a bit mask of the bytes written so far.
bus_data_t   model_ram_data  [int unsigned];
bus_data_t   model_ram_known [int unsigned];
gpo_t        model_gp_o = '0;
logic [31:0] rng_state  = 32'd98;

function automatic bus_data_t be_to_mask(bus_be_t be);
  bus_data_t mask;
  for (int i = 0; i < 4; i++) begin
    mask[8*i +: 8] = {8{be[i]}};
  end
  return mask;
endfunction

function automatic int unsigned ram_word_index(bus_addr_t addr);
  return (addr & ~RamMask) >> 2;
endfunction

function void model_ram_write(bus_addr_t addr, bus_data_t wdata, bus_be_t be);
  int unsigned idx;
  bus_data_t   mask;
  idx  = ram_word_index(addr);
  mask = be_to_mask(be);
  if (!model_ram_data.exists(idx)) begin
    model_ram_data[idx]  = '0;
    model_ram_known[idx] = '0;
  end
  model_ram_data[idx]  = (model_ram_data[idx] & ~mask) | (wdata & mask);
  model_ram_known[idx] = model_ram_known[idx] | mask;
endfunction

function bus_data_t model_ram_read(bus_addr_t addr);
  int unsigned idx;
  idx = ram_word_index(addr);
  return model_ram_data.exists(idx) ? model_ram_data[idx] : '0;
endfunction

// Bytes never written hold no defined value.
function bus_data_t model_ram_mask(bus_addr_t addr);
  int unsigned idx;
  idx = ram_word_index(addr);
  return model_ram_known.exists(idx) ? model_ram_known[idx] : '0;
endfunction

function void model_gpio_write(bus_data_t wdata, bus_be_t be);
  if (be[0]) model_gp_o[7:0]  = wdata[7:0];
  if (be[1]) model_gp_o[15:8] = wdata[15:8];
endfunction

function automatic bus_device_e model_decode(bus_addr_t addr);
  if ((addr & RamMask) == RamStart) return Ram;
  if ((addr & GpioMask) == GpioStart) return Gpio;
  if ((addr & TimerMask) == TimerStart) return Timer;
  return NoDev;
endfunction

// Unmapped, or a timer offset past mtimecmp.
function automatic bit model_err(bus_addr_t addr);
  bus_device_e dev;
  dev = model_decode(addr);
  if (dev == NoDev) return 1'b1;
  if (dev == Timer) return addr[DevOffsWidth-1:0] >= 12'h010;
  return 1'b0;
endfunction

function logic [31:0] xorshift32();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

`endif

/* bench/tb_demo_soc.sv */
module tb_demo_soc import soc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RespTimeout  = 20;
  localparam int IrqTimeout   = 200;
  localparam int NumRamWrites = 32;
  localparam int BurstLen     = 8;

  typedef struct packed {
    bus_data_t   data;
    bus_data_t   mask;  // Bytes of rdata that are compared.
    logic        err;
    logic [63:0] due;   // Cycle in which rvalid must be high.
  } resp_t;

  logic      clk_sys_i = 1'b0;
  logic      rst_sys_ni;
  logic      bus_req_i;
  logic      bus_we_i;
  bus_addr_t bus_addr_i;
  bus_be_t   bus_be_i;
  bus_data_t bus_wdata_i;
  logic      bus_rvalid_o;
  bus_data_t bus_rdata_o;
  logic      bus_err_o;
  gpi_t      gp_i;
  gpo_t      gp_o;
  logic      timer_irq_o;

  resp_t       exp_q [$];
  bus_data_t   last_rdata;
  logic [63:0] cycle_cnt      = '0;
  gpi_t        model_gp_i     = '0;
  mtime_t      model_mtimecmp = '1;

  `include "tb_demo_soc_model.svh"

  demo_soc_top uut (.*);

  always #4 clk_sys_i = ~clk_sys_i;

  always @(posedge clk_sys_i) cycle_cnt <= cycle_cnt + 64'd1;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED time %0t ns: %s is 0x%0h, expected 0x%0h",
                         $time, name, actual, expected));
    end
  endtask

  function automatic bus_addr_t dev_addr(bus_addr_t base, logic [DevOffsWidth-1:0] offs);
    return base | bus_addr_t'(offs);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model of reads and writes
  ////////////////////////////////////////////////////////////////////////////

  function automatic void ref_read(input bus_addr_t addr, output bus_data_t data,
                                   output bus_data_t mask);
    logic [DevOffsWidth-1:0] offs;
    offs = {addr[DevOffsWidth-1:2], 2'b00};
    data = '0;
    mask = '1;
    case (model_decode(addr))
      Ram: begin
        data = model_ram_read(addr);
        mask = model_ram_mask(addr);
      end
      Gpio: begin
        if (offs == GpioOutOffs) data = bus_data_t'(model_gp_o);
        if (offs == GpioInOffs) data = bus_data_t'(model_gp_i);
      end
      Timer: begin
        if (offs == MtimecmpLoOffs) data = model_mtimecmp[31:0];
        else if (offs == MtimecmpHiOffs) data = model_mtimecmp[63:32];
        else mask = '0;  // Running counter or bad offset.
      end
      default: ;
    endcase
  endfunction

  function automatic void apply_write(bus_addr_t addr, bus_be_t be, bus_data_t wdata);
    logic [DevOffsWidth-1:0] offs;
    bus_data_t               mask;
    offs = {addr[DevOffsWidth-1:2], 2'b00};
    mask = be_to_mask(be);
    case (model_decode(addr))
      Ram: model_ram_write(addr, wdata, be);
      Gpio: if (offs == GpioOutOffs) model_gpio_write(wdata, be);
      Timer: begin
        if (offs == MtimecmpLoOffs) begin
          model_mtimecmp[31:0] = (model_mtimecmp[31:0] & ~mask) | (wdata & mask);
        end
        if (offs == MtimecmpHiOffs) begin
          model_mtimecmp[63:32] = (model_mtimecmp[63:32] & ~mask) | (wdata & mask);
        end
      end
      default: ;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue_access(input logic we, input bus_addr_t addr, input bus_be_t be,
                              input bus_data_t wdata);
    resp_t     resp;
    bus_data_t data;
    bus_data_t mask;
    @(posedge clk_sys_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= we;
    bus_addr_i  <= addr;
    bus_be_i    <= be;
    bus_wdata_i <= wdata;
    data = '0;
    mask = '0;  // Write data is not compared.
    if (we) apply_write(addr, be, wdata);
    else ref_read(addr, data, mask);
    resp.data = data;
    resp.mask = mask;
    resp.err  = model_err(addr);
    resp.due  = cycle_cnt + 64'd2;
    exp_q.push_back(resp);
  endtask

  task automatic release_bus();
    @(posedge clk_sys_i);
    bus_req_i <= 1'b0;
    bus_we_i  <= 1'b0;
  endtask

  task automatic wait_responses();
    for (int n = 0; exp_q.size() != 0; n++) begin
      if (n >= RespTimeout) fail_run("Timed out waiting for outstanding bus responses");
      @(negedge clk_sys_i);
    end
  endtask

  task automatic read_word(input bus_addr_t addr);
    issue_access(1'b0, addr, 4'hF, '0);
    release_bus();
    wait_responses();
  endtask

  task automatic write_word(input bus_addr_t addr, input bus_be_t be, input bus_data_t wdata);
    issue_access(1'b1, addr, be, wdata);
    release_bus();
    wait_responses();
  endtask

  task automatic wait_irq(input logic level, input int limit);
    for (int n = 0; timer_irq_o !== level; n++) begin
      if (n >= limit) fail_run($sformatf("timer_irq_o did not reach %0b in time", level));
      @(negedge clk_sys_i);
    end
  endtask

  // Response checker, sampled mid-cycle.
  always @(negedge clk_sys_i) begin
    resp_t resp;
    if (rst_sys_ni === 1'b1) begin
      if (bus_rvalid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          fail_run("A bus response arrived with no request outstanding");
        end else begin
          resp = exp_q.pop_front();
          check("response cycle", cycle_cnt, resp.due);
          check("bus_err_o", 64'(bus_err_o), 64'(resp.err));
          check("bus_rdata_o", 64'(bus_rdata_o & resp.mask), 64'(resp.data & resp.mask));
          last_rdata = bus_rdata_o;
        end
      end else begin
        check("bus_rvalid_o", 64'(bus_rvalid_o), 64'd0);
        if (exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
          fail_run("A bus response did not arrive in the cycle after its request");
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    bus_addr_t ram_addr [NumRamWrites];
    logic [31:0] r;
    bus_be_t     be;
    bus_data_t   wd;
    gpo_t        old_gp;
    bus_data_t   t_first;
    bus_data_t   t_second;
    mtime_t      target;
    rst_sys_ni  <= 1'b0;
    bus_req_i   <= 1'b0;
    bus_we_i    <= 1'b0;
    bus_addr_i  <= '0;
    bus_be_i    <= '0;
    bus_wdata_i <= '0;
    gp_i        <= '0;
    repeat (16) @(posedge clk_sys_i);
    rst_sys_ni <= 1'b1;

    @(negedge clk_sys_i);
    check("bus_rvalid_o", 64'(bus_rvalid_o), 64'd0);
    check("gp_o", 64'(gp_o), 64'd0);
    check("timer_irq_o", 64'(timer_irq_o), 64'd0);
    read_word(dev_addr(TimerStart, MtimecmpLoOffs));
    read_word(dev_addr(TimerStart, MtimecmpHiOffs));

    // Random RAM writes back to back, then single reads and one read burst.
    for (int i = 0; i < NumRamWrites; i++) begin
      r           = xorshift32();
      ram_addr[i] = RamStart | ((r % RamWords) << 2);
      r           = xorshift32();
      be          = r[3:0];
      wd          = xorshift32();
      issue_access(1'b1, ram_addr[i], be, wd);
    end
    release_bus();
    wait_responses();
    for (int i = 0; i < NumRamWrites; i++) read_word(ram_addr[i]);
    for (int i = 0; i < BurstLen; i++) issue_access(1'b0, ram_addr[i], 4'hF, '0);
    release_bus();
    wait_responses();

    // GPIO output changes one cycle after the request.
    for (int i = 0; i < 4; i++) begin
      r      = xorshift32();
      be     = r[3:0];
      wd     = xorshift32();
      old_gp = model_gp_o;
      issue_access(1'b1, dev_addr(GpioStart, GpioOutOffs), be, wd);
      @(negedge clk_sys_i);
      check("gp_o", 64'(gp_o), 64'(old_gp));
      release_bus();
      @(negedge clk_sys_i);
      check("gp_o", 64'(gp_o), 64'(model_gp_o));
      wait_responses();
      read_word(dev_addr(GpioStart, GpioOutOffs));
    end
    r = xorshift32();
    @(posedge clk_sys_i);
    gp_i       <= r[7:0];
    model_gp_i =  r[7:0];
    for (int i = 0; i < 3; i++) @(posedge clk_sys_i);
    read_word(dev_addr(GpioStart, GpioInOffs));
    read_word(dev_addr(GpioStart, 12'h008));

    // Timer.
    read_word(dev_addr(TimerStart, MtimeLoOffs));
    t_first = last_rdata;
    read_word(dev_addr(TimerStart, MtimeLoOffs));
    t_second = last_rdata;
    check("mtime low increases", 64'(t_second > t_first), 64'd1);
    read_word(dev_addr(TimerStart, MtimeHiOffs));
    target = {last_rdata, t_second} + 64'd50;
    write_word(dev_addr(TimerStart, MtimecmpLoOffs), 4'hF, target[31:0]);
    write_word(dev_addr(TimerStart, MtimecmpHiOffs), 4'hF, target[63:32]);
    check("timer_irq_o", 64'(timer_irq_o), 64'd0);
    wait_irq(1'b1, IrqTimeout);
    write_word(dev_addr(TimerStart, MtimecmpHiOffs), 4'hF, '1);
    write_word(dev_addr(TimerStart, MtimecmpLoOffs), 4'hF, '1);
    wait_irq(1'b0, 4);
    read_word(dev_addr(TimerStart, MtimecmpLoOffs));

    // Error responses, then a RAM access right behind one.
    read_word(32'h4000_0000);
    write_word(32'h4000_0000, 4'hF, 32'hdead_beef);
    read_word(32'h8000_1000);
    write_word(32'h8000_1000, 4'hF, 32'h1234_5678);
    read_word(dev_addr(TimerStart, 12'h010));
    write_word(dev_addr(TimerStart, 12'h010), 4'hF, 32'h0);
    issue_access(1'b0, 32'h4000_0000, 4'hF, '0);
    issue_access(1'b0, ram_addr[0], 4'hF, '0);
    release_bus();
    wait_responses();

    $display("Test completed successfully");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
hw/soc_pkg.sv
hw/bus_decoder.sv
hw/soc_ram.sv
hw/gpio_regs.sv
hw/machine_timer.sv
hw/demo_soc_top.sv
bench/tb_demo_soc.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := tb_demo_soc
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
